// ==== bench/aluPatterns.hex ====
// program length, program words {op, dst, src1, src0}
// then led count and the expected led bytes in output order
19
4010005
4020003
1030102
9000300
2040201
9000400
A050102
9000500
4061234
3000604
900FE00
900FF00
4070000
4080001
4090002
1070708
9000700
50F0709
7160000
9000100
6140000
9000600
A010108
8000000
9000600
09
// 5+3, 3-5, 5<<3
08
FE
28
// 0x1234 * -2 as RL then RH
98
FF
// loop count, then r1 after the subroutine
01
02
03
0A

// ==== bench/miniAluTb.sv ====
module miniAluTb import miniAluPkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	logic  Clock;
	logic  rst;
	logic  run;
	wbReqT hostReq;
	wbRspT hostRsp;
	ledT   led;
	logic  ledWrite;

	// length, program, led count, led bytes
	logic [27:0] patterns [0:63];
	int          progLen;
	int          ledCount;
	int          ledBase;
	int          errors;
	int          errorMark;
	int          testsPassed;
	int          testsFailed;
	int          cycleCount;
	logic [31:0] lfsrState;
	logic        runDone;
	ledT         seenLeds [$];

	miniAluTop DUT
	(
		.Clock    (Clock),
		.rst      (rst),
		.run      (run),
		.hostReq  (hostReq),
		.hostRsp  (hostRsp),
		.led      (led),
		.ledWrite (ledWrite)
	);

	bind memArbiter miniAlu_props props
	(
		.Clock      (Clock),
		.rst        (rst),
		.run        (run),
		.ack        (hostRsp.ack),
		.fetchValid (fetchValid),
		.memWe      (memWe)
	);

	always #20 Clock = ~Clock;

	// ##########################################################
	// helpers
	// ##########################################################

	// taps 32 22 2 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	task automatic randomBits(input int count, output int value);
		value = 0;
		for (int i = 0; i < count; i++)
		begin
			lfsrState = lfsrNext(lfsrState);
			value = (value << 1) | int'(lfsrState[0]);
		end
	endtask

	task automatic compare(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
		begin
			$display("ERR %s expected %h actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic startTest();
		errorMark = errors;
	endtask

	task automatic finishTest(input string name);
		if (errors == errorMark)
		begin
			testsPassed++;
			$display("%s: pass", name);
		end
		else
		begin
			testsFailed++;
			$display("%s: fail with %0d mismatches", name, errors - errorMark);
		end
	endtask

	task automatic checkIdle(input string name);
		compare({name, " led"}, 0, led);
		compare({name, " ledWrite"}, 0, ledWrite);
		compare({name, " ack"}, 0, hostRsp.ack);
	endtask

	// ten rising edges with rst high and a read pending, then one more cycle of checks
	task automatic applyReset(input string name);
		rst = 1'b1;
		run = 1'b0;
		hostReq = '0;
		hostReq.cyc = 1'b1;
		hostReq.stb = 1'b1;
		repeat (10)
		begin
			@(negedge Clock);
			checkIdle(name);
		end
		rst = 1'b0;
		hostReq = '0;
		@(negedge Clock);
		checkIdle(name);
	endtask

	// one wishbone classic cycle with acks counted up to the cycle after the first
	task automatic hostAccess(input logic we, input addrT adr, input instrT wdata,
		output instrT rdata, output int acks);
		hostReq.cyc = 1'b1;
		hostReq.stb = 1'b1;
		hostReq.we  = we;
		hostReq.adr = adr;
		hostReq.dat = wdata;
		@(negedge Clock);
		while (!hostRsp.ack)
			@(negedge Clock);
		acks  = 1;
		rdata = hostRsp.dat;
		hostReq.cyc = 1'b0;
		hostReq.stb = 1'b0;
		hostReq.we  = 1'b0;
		@(negedge Clock);
		if (hostRsp.ack)
			acks++;
	endtask

	task automatic collectLeds(output int cycles);
		cycles = 0;
		while (seenLeds.size() < ledCount)
		begin
			@(negedge Clock);
			cycles++;
			if (ledWrite)
				seenLeds.push_back(led);
		end
		// program parks in a jump loop so nothing more may reach the port
		repeat (32)
		begin
			@(negedge Clock);
			if (ledWrite)
				seenLeds.push_back(led);
		end
		runDone = 1'b1;
	endtask

	task automatic hostTraffic(input logic enable);
		int    gap;
		int    pick;
		int    acks;
		addrT  adr;
		instrT word;
		while (enable && !runDone)
		begin
			randomBits(3, gap);
			repeat (gap) @(negedge Clock);
			randomBits(5, pick);
			adr = addrT'(pick % progLen);
			hostAccess(1'b0, adr, '0, word, acks);
			compare($sformatf("contention read %0d", adr), patterns[1 + adr], word);
			compare($sformatf("contention ack %0d", adr), 1, acks);
		end
	endtask

	task automatic runProgram(input logic withHost, output int cycles);
		seenLeds.delete();
		runDone = 1'b0;
		run = 1'b1;
		fork
			collectLeds(cycles);
			hostTraffic(withHost);
		join
		run = 1'b0;
	endtask

	task automatic checkLeds(input string name, input int first, input int last);
		for (int i = first; i <= last; i++)
			compare($sformatf("%s led %0d", name, i), patterns[ledBase + i], seenLeds[i]);
	endtask

	// ##########################################################
	// test sequence
	// ##########################################################
	task automatic runTests();
		instrT word;
		int    acks;
		int    quietCycles;
		int    busyCycles;
		startTest();
		applyReset("reset");
		finishTest("reset");

		startTest();
		for (int a = 0; a < progLen; a++)
		begin
			hostAccess(1'b1, addrT'(a), patterns[1 + a], word, acks);
			compare($sformatf("load ack %0d", a), 1, acks);
		end
		finishTest("load");

		startTest();
		for (int a = 0; a < progLen; a++)
		begin
			hostAccess(1'b0, addrT'(a), '0, word, acks);
			compare($sformatf("readback word %0d", a), patterns[1 + a], word);
			compare($sformatf("readback ack %0d", a), 1, acks);
		end
		finishTest("readback");

		// led slots 0..2 arithmetic, 3..4 product halves, 5..8 branches
		startTest();
		runProgram(1'b0, quietCycles);
		checkLeds("arith", 0, 2);
		finishTest("arith");
		startTest();
		checkLeds("multiply", 3, 4);
		finishTest("multiply");
		startTest();
		checkLeds("control", 5, ledCount - 1);
		compare("control led count", ledCount, seenLeds.size());
		finishTest("control");

		startTest();
		applyReset("contention reset");
		runProgram(1'b1, busyCycles);
		checkLeds("contention", 0, ledCount - 1);
		compare("contention led count", ledCount, seenLeds.size());
		// the first read lands in straight-line code, so a lost fetch shows as a later led
		if (busyCycles <= quietCycles)
		begin
			$display("contention: host reads never stalled the core fetch");
			errors++;
		end
		finishTest("contention");

		startTest();
		compare("assertion failures", 0, DUT.arbiter.props.failCount);
		finishTest("assertions");
	endtask

	initial
	begin
		Clock       = 1'b0;
		rst         = 1'b1;
		run         = 1'b0;
		hostReq     = '0;
		errors      = 0;
		errorMark   = 0;
		testsPassed = 0;
		testsFailed = 0;
		runDone     = 1'b0;
		lfsrState   = 32'h5a5633b7;
		$readmemh("bench/aluPatterns.hex", patterns);
		progLen  = int'(patterns[0]);
		ledCount = int'(patterns[progLen + 1]);
		ledBase  = progLen + 2;
		if ($isunknown(patterns[0]) || progLen == 0 || ledBase + ledCount > 64)
		begin
			$display("pattern file bench/aluPatterns.hex is missing or malformed");
			errors++;
		end
		else
			runTests();
		$display("tests passed %0d, failed %0d, mismatches %0d",
			testsPassed, testsFailed, errors);
		if (testsFailed == 0 && errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	// watchdog sized from the pattern file
	initial
	begin
		int limit;
		cycleCount = 0;
		@(posedge Clock);
		limit = progLen * 8 + ledCount * 64 + 200;
		while (cycleCount < limit)
		begin
			@(posedge Clock);
			cycleCount++;
		end
		$display("timeout: the program never finished within %0d cycles", limit);
		$display("Test FAILED");
		$finish;
	end

endmodule

// ==== bench/miniAlu_props.sv ====
module miniAlu_props
(
	input logic Clock,
	input logic rst,
	input logic run,
	input logic ack,
	input logic fetchValid,
	input logic memWe
);

	timeunit 1ns;
	timeprecision 1ps;

	int failCount = 0;

	// one ack per request, the host has to drop stb in between
	ackSingle: assert property (@(posedge Clock) disable iff (rst) ack |=> !ack)
	else
	begin
		failCount++;
		$error("ack high in two consecutive cycles");
	end

	// a host write never overlaps a valid fetch
	noWriteFetch: assert property (@(posedge Clock) !(fetchValid && memWe))
	else
	begin
		failCount++;
		$error("fetchValid and memWe high together");
	end

	ackAfterReset: assert property (@(posedge Clock) rst |=> !ack)
	else
	begin
		failCount++;
		$error("ack high in the cycle after reset");
	end

	// core is parked while run is low
	fetchNeedsRun: assert property (@(posedge Clock) !run |-> !fetchValid)
	else
	begin
		failCount++;
		$error("fetchValid high while run is low");
	end

endmodule

// ==== logic/dataRam.sv ====
module dataRam import miniAluPkg::*;
(
	input  logic Clock,
	input  logic wrEn,
	input  addrT wrAddr,
	input  wordT wrData,
	input  addrT rdAddr0,
	input  addrT rdAddr1,
	output wordT rdData0,
	output wordT rdData1
);

	// one word per possible operand address
	wordT mem [0:(1 << $bits(addrT))-1];

	always_ff @(posedge Clock)
	begin
		if (wrEn)
			mem[wrAddr] <= wrData;
	end

	// both source operands read in the same cycle
	assign rdData0 = mem[rdAddr0];
	assign rdData1 = mem[rdAddr1];

endmodule

// ==== logic/memArbiter.sv ====
module memArbiter import miniAluPkg::*;
(
	input  logic  Clock,
	input  logic  rst,
	input  logic  run,
	input  wbReqT hostReq,
	output wbRspT hostRsp,
	input  addrT  fetchAddr,
	output logic  fetchValid,
	output addrT  memAddr,
	output logic  memWe,
	output instrT memWrData,
	input  instrT memRdData,
	output instrT fetchInstr
);

	logic  ackQ;
	logic  hostGrant;
	instrT rspDat;

	// ##########################################################
	// ownership of the program memory
	// ##########################################################

	// host wins, but not again in its own ack cycle
	assign hostGrant  = hostReq.cyc && hostReq.stb && !ackQ;
	assign fetchValid = !hostGrant && run;

	assign memAddr    = hostGrant ? hostReq.adr : fetchAddr;
	assign memWe      = hostGrant && hostReq.we;
	assign memWrData  = hostReq.dat;
	assign fetchInstr = memRdData;

	// ack one cycle after grant
	always_ff @(posedge Clock)
	begin
		if (rst)
			ackQ <= 1'b0;
		else
			ackQ <= hostGrant;
	end

	// memory address moves back to the fetch side, so hold the read word
	always_ff @(posedge Clock)
	begin
		if (hostGrant)
			rspDat <= memRdData;
	end

	assign hostRsp.ack = ackQ;
	assign hostRsp.dat = rspDat;

endmodule

// ==== logic/miniAlu.sv ====
module miniAlu import miniAluPkg::*;
(
	input  logic  Clock,
	input  logic  rst,
	output addrT  fetchAddr,
	input  instrT fetchInstr,
	input  logic  fetchValid,
	output addrT  rdAddr0,
	output addrT  rdAddr1,
	input  wordT  rdData0,
	input  wordT  rdData1,
	output logic  wrEn,
	output addrT  wrAddr,
	output wordT  wrData,
	output ledT   led,
	output logic  ledWrite
);

	addrT   ip;
	addrT   retIp;
	instrT  ir;
	wordT   rl;
	wordT   rh;
	opcodeT op;
	addrT   dst;
	addrT   src1;
	addrT   src0;
	wordT   srcData1;
	wordT   srcData0;
	logic signed [31:0] result;
	logic   branchTaken;
	addrT   branchTarget;
	logic   ledEn;

	// RL/RH override the RAM word at their alias addresses
	function automatic wordT pickOperand(input addrT sel, input wordT ramData,
		input wordT lo, input wordT hi);
		wordT value;
		if (sel == addrRl)
			value = lo;
		else if (sel == addrRh)
			value = hi;
		else
			value = ramData;
		return value;
	endfunction

	// ##########################################################
	// fetch and instruction pointer
	// ##########################################################
	assign fetchAddr = ip;

	always_ff @(posedge Clock)
	begin
		if (rst)
			ip <= '0;
		else if (branchTaken)
			ip <= branchTarget;
		else if (fetchValid)
			ip <= ip + 1'b1;
	end

	// a stalled fetch or the slot behind a taken branch becomes a NOP
	always_ff @(posedge Clock)
	begin
		if (rst || branchTaken || !fetchValid)
		begin
			ir              <= '0;
			ir[opMsb:opLsb] <= NOP;
		end
		else
			ir <= fetchInstr;
	end

	// single level return, ip already points past the call
	always_ff @(posedge Clock)
	begin
		if (rst)
			retIp <= '0;
		else if (op == CALL)
			retIp <= ip;
	end

	// ##########################################################
	// decode and operands
	// ##########################################################
	assign op   = opcodeT'(ir[opMsb:opLsb]);
	assign dst  = ir[dstMsb:dstLsb];
	assign src1 = ir[src1Msb:src1Lsb];
	assign src0 = ir[src0Msb:src0Lsb];

	assign rdAddr0 = src0;
	assign rdAddr1 = src1;

	assign srcData0 = pickOperand(src0, rdData0, rl, rh);
	assign srcData1 = pickOperand(src1, rdData1, rl, rh);

	// ##########################################################
	// execute
	// ##########################################################
	always_comb
	begin
		result      = '0;
		wrEn        = 1'b0;
		branchTaken = 1'b0;
		ledEn       = 1'b0;
		case (op)
			NOP:
			begin
				result = '0;
			end
			ADD:
			begin
				result = srcData1 + srcData0;
				wrEn   = 1'b1;
			end
			SUB:
			begin
				result = srcData1 - srcData0;
				wrEn   = 1'b1;
			end
			SMUL:
			begin
				// full product goes to RH:RL only
				result = srcData1 * srcData0;
			end
			STO:
			begin
				result = {16'h0, src1, src0};
				wrEn   = 1'b1;
			end
			SHL:
			begin
				result = srcData1 << srcData0;
				wrEn   = 1'b1;
			end
			BLE:
			begin
				branchTaken = (srcData1 <= srcData0);
			end
			JMP, CALL, RET:
			begin
				branchTaken = 1'b1;
			end
			LED:
			begin
				ledEn = 1'b1;
			end
			default:
			begin
				result = '0;
			end
		endcase
	end

	assign branchTarget = (op == RET) ? retIp : dst;

	assign wrAddr = dst;
	assign wrData = result[15:0];

	// product halves
	always_ff @(posedge Clock)
	begin
		if (op == SMUL)
		begin
			rl <= result[15:0];
			rh <= result[31:16];
		end
	end

	// led port, strobe lines up with the new value
	always_ff @(posedge Clock)
	begin
		if (rst)
		begin
			led      <= '0;
			ledWrite <= 1'b0;
		end
		else
		begin
			ledWrite <= ledEn;
			if (ledEn)
				led <= srcData1[7:0];
		end
	end

endmodule

// ==== logic/miniAluPkg.sv ====
package miniAluPkg;

	// ##########################################################
	// basic widths
	// ##########################################################
	typedef logic [27:0] instrT;
	typedef logic [7:0] addrT;
	typedef logic signed [15:0] wordT;
	typedef logic [7:0] ledT;

	typedef enum logic [3:0]
	{
		NOP  = 4'd0,
		ADD  = 4'd1,
		SUB  = 4'd2,
		SMUL = 4'd3,
		STO  = 4'd4,
		BLE  = 4'd5,
		JMP  = 4'd6,
		CALL = 4'd7,
		RET  = 4'd8,
		LED  = 4'd9,
		SHL  = 4'd10
	} opcodeT;

	// instruction fields
	localparam int opMsb   = 27;
	localparam int opLsb   = 24;
	localparam int dstMsb  = 23;
	localparam int dstLsb  = 16;
	localparam int src1Msb = 15;
	localparam int src1Lsb = 8;
	localparam int src0Msb = 7;
	localparam int src0Lsb = 0;

	// operand addresses that alias the product halves
	localparam addrT addrRl = 8'hFE;
	localparam addrT addrRh = 8'hFF;

	localparam int progDepth = 256;

	// ##########################################################
	// wishbone classic host port
	// ##########################################################
	typedef struct packed
	{
		logic  cyc;
		logic  stb;
		logic  we;
		addrT  adr;
		instrT dat;
	} wbReqT;

	typedef struct packed
	{
		logic  ack;
		instrT dat;
	} wbRspT;

endpackage

// ==== logic/miniAluTop.sv ====
module miniAluTop import miniAluPkg::*;
(
	input  logic  Clock,
	input  logic  rst,
	input  logic  run,
	input  wbReqT hostReq,
	output wbRspT hostRsp,
	output ledT   led,
	output logic  ledWrite
);

	// fetch path
	addrT  fetchAddr;
	instrT fetchInstr;
	logic  fetchValid;

	// program memory port
	addrT  memAddr;
	logic  memWe;
	instrT memWrData;
	instrT memRdData;

	// data RAM port
	addrT  rdAddr0;
	addrT  rdAddr1;
	wordT  rdData0;
	wordT  rdData1;
	logic  wrEn;
	addrT  wrAddr;
	wordT  wrData;

	memArbiter arbiter
	(
		.Clock      (Clock),
		.rst        (rst),
		.run        (run),
		.hostReq    (hostReq),
		.hostRsp    (hostRsp),
		.fetchAddr  (fetchAddr),
		.fetchValid (fetchValid),
		.memAddr    (memAddr),
		.memWe      (memWe),
		.memWrData  (memWrData),
		.memRdData  (memRdData),
		.fetchInstr (fetchInstr)
	);

	progMem progStore
	(
		.Clock     (Clock),
		.memAddr   (memAddr),
		.memWe     (memWe),
		.memWrData (memWrData),
		.memRdData (memRdData)
	);

	dataRam data
	(
		.Clock   (Clock),
		.wrEn    (wrEn),
		.wrAddr  (wrAddr),
		.wrData  (wrData),
		.rdAddr0 (rdAddr0),
		.rdAddr1 (rdAddr1),
		.rdData0 (rdData0),
		.rdData1 (rdData1)
	);

	miniAlu core
	(
		.Clock      (Clock),
		.rst        (rst),
		.fetchAddr  (fetchAddr),
		.fetchInstr (fetchInstr),
		.fetchValid (fetchValid),
		.rdAddr0    (rdAddr0),
		.rdAddr1    (rdAddr1),
		.rdData0    (rdData0),
		.rdData1    (rdData1),
		.wrEn       (wrEn),
		.wrAddr     (wrAddr),
		.wrData     (wrData),
		.led        (led),
		.ledWrite   (ledWrite)
	);

endmodule

// ==== logic/progMem.sv ====
module progMem import miniAluPkg::*;
(
	input  logic  Clock,
	input  addrT  memAddr,
	input  logic  memWe,
	input  instrT memWrData,
	output instrT memRdData
);

	// program storage, contents only come from the host port
	instrT mem [0:progDepth-1];

	always_ff @(posedge Clock)
	begin
		if (memWe)
			mem[memAddr] <= memWrData;
	end

	// read is asynchronous so a fetch completes in the grant cycle
	assign memRdData = mem[memAddr];

endmodule

// ==== project.f ====
logic/miniAluPkg.sv
logic/progMem.sv
logic/memArbiter.sv
logic/dataRam.sv
logic/miniAlu.sv
logic/miniAluTop.sv
bench/miniAlu_props.sv
bench/miniAluTb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module miniAluTb -f project.f -o miniAluSim \
	&& ./obj_dir/miniAluSim | tee /dev/stderr | grep -qx "Test OK" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
